//--- verilog.f
+incdir+src
+incdir+verification
src/load_unit_pkg.sv
src/load_align.sv
src/load_buffer.sv
src/load_ctrl.sv
src/load_unit.sv
verification/tb_load_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       := tb_load_unit
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Simulation finished: PASS

SOURCES := $(wildcard src/*.sv src/*.svh verification/*.sv verification/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_load_unit_tasks.svh
// directed load unit tests that the testbench top includes

`ifndef TB_LOAD_UNIT_TASKS_SVH
`define TB_LOAD_UNIT_TASKS_SVH

// all handshake outputs idle once reset is gone
task automatic test_reset();
  int unsigned c;
  for (c = 0; c < 3; c++) begin
    #1;
    if (dcache_req_o.data_req !== 1'b0) report_error("data_req high after reset");
    if (dcache_req_o.tag_valid !== 1'b0) report_error("tag_valid high after reset");
    if (dcache_req_o.kill_req !== 1'b0) report_error("kill_req high after reset");
    if (pop_ld_o !== 1'b0) report_error("pop_ld_o high after reset");
    if (valid_o !== 1'b0) report_error("valid_o high after reset");
    @(negedge clk_i);
  end
  finish_test("reset");
endtask

// every op at every naturally aligned offset with an immediate grant
task automatic test_extension();
  load_unit_pkg::load_req_t req;
  load_unit_pkg::req_id_t   id;
  load_unit_pkg::ld_op_e    op;
  load_unit_pkg::addr_t     addr;
  int unsigned              i;
  int unsigned              n;
  int unsigned              off;
  int unsigned              count;
  count = 0;
  for (i = 0; i < 7; i++) begin
    op = load_unit_pkg::ld_op_e'(3'(i));
    n  = op_bytes(op);
    for (off = 0; off < 8; off += n) begin
      // each op gets its own words so the sign bits vary
      addr = 32'h8000_1A00 + i * 64 + off;
      req  = make_req(count, addr, op);
      issue_load(req, 0, id);
      return_response(id, req, 1'b1);
      count++;
    end
  end
  finish_test("result extension");
endtask

// grant held back for a random number of cycles
task automatic test_delayed_grant();
  load_unit_pkg::load_req_t req;
  load_unit_pkg::req_id_t   id;
  load_unit_pkg::addr_t     addr;
  int unsigned              delay;
  int unsigned              k;
  for (k = 0; k < 4; k++) begin
    delay = 1 + $urandom % 6;
    addr  = $urandom;
    addr[2:0] = 3'b000;
    req = make_req(k + 4, addr, load_unit_pkg::LD);
    issue_load(req, delay, id);
    return_response(id, req, 1'b1);
  end
  finish_test("delayed grant");
endtask

// pending store to the same page offset holds the request back
task automatic test_page_offset_stall();
  load_unit_pkg::load_req_t req;
  load_unit_pkg::req_id_t   id;
  int unsigned              c;
  req = make_req(5, 32'h0004_2A36, load_unit_pkg::LH);
  @(negedge clk_i);
  valid_i               = 1'b1;
  ld_req_i              = req;
  page_offset_matches_i = 1'b1;
  for (c = 0; c < 4; c++) begin
    #1;
    if (dcache_req_o.data_req !== 1'b0) report_error("data_req high during a store match");
    if (page_offset_o !== req.addr[11:0]) begin
      report_error($sformatf("page offset %h, expected %h", page_offset_o, req.addr[11:0]));
    end
    @(negedge clk_i);
  end
  page_offset_matches_i = 1'b0;
  #1;
  // request leaves only in the cycle after the match clears
  if (dcache_req_o.data_req !== 1'b0) report_error("data_req high as the match cleared");
  issue_load(req, 0, id);
  return_response(id, req, 1'b1);
  finish_test("page offset stall");
endtask

// two loads in flight are answered newest first while a third waits
task automatic test_out_of_order();
  load_unit_pkg::load_req_t req_a;
  load_unit_pkg::load_req_t req_b;
  load_unit_pkg::load_req_t req_c;
  load_unit_pkg::req_id_t   id_a;
  load_unit_pkg::req_id_t   id_b;
  load_unit_pkg::req_id_t   id_c;
  int unsigned              c;
  req_a = make_req(1, 32'h0010_0105, load_unit_pkg::LBU);
  req_b = make_req(2, 32'h0020_0A04, load_unit_pkg::LW);
  req_c = make_req(3, 32'h0030_0FF2, load_unit_pkg::LHU);
  issue_load(req_a, 0, id_a);
  issue_load(req_b, 0, id_b);
  // an empty buffer hands out its lowest slot first
  if (id_a !== 0 || id_b !== 1) begin
    report_error($sformatf("load ids %0d and %0d, expected 0 and 1", id_a, id_b));
  end
  @(negedge clk_i);
  valid_i               = 1'b1;
  ld_req_i              = req_c;
  dcache_rsp_i.data_gnt = 1'b1;
  for (c = 0; c < 3; c++) begin
    #1;
    if (dcache_req_o.data_req !== 1'b0) report_error("data_req high with a full buffer");
    if (pop_ld_o !== 1'b0) report_error("pop_ld_o high with a full buffer");
    @(negedge clk_i);
  end
  return_response(id_b, req_b, 1'b1);
  #1;
  // freed slot is taken right away
  if (dcache_req_o.data_req !== 1'b1 || pop_ld_o !== 1'b1) begin
    report_error("third load not granted after a slot was freed");
  end
  id_c = dcache_req_o.data_id;
  if (id_c !== id_b) report_error($sformatf("third load id %0d, expected %0d", id_c, id_b));
  @(negedge clk_i);
  valid_i               = 1'b0;
  dcache_rsp_i.data_gnt = 1'b0;
  #1;
  if (dcache_req_o.tag_valid !== 1'b1) report_error("tag_valid low for the third load");
  return_response(id_a, req_a, 1'b1);
  return_response(id_c, req_c, 1'b1);
  finish_test("out-of-order responses");
endtask

// a flush with a load outstanding drops its response
task automatic test_flush();
  load_unit_pkg::load_req_t req_a;
  load_unit_pkg::load_req_t req_b;
  load_unit_pkg::req_id_t   id_a;
  load_unit_pkg::req_id_t   id_b;
  req_a = make_req(6, 32'h0040_0310, load_unit_pkg::LW);
  req_b = make_req(7, 32'h0050_0721, load_unit_pkg::LB);
  issue_load(req_a, 0, id_a);
  @(negedge clk_i);
  flush_i = 1'b1;
  @(negedge clk_i);
  flush_i = 1'b0;
  #1;
  if (dcache_req_o.kill_req !== 1'b1 || dcache_req_o.tag_valid !== 1'b1) begin
    report_error("no kill cycle with kill_req and tag_valid after the flush");
  end
  return_response(id_a, req_a, 1'b0);
  // unit is usable again
  issue_load(req_b, 0, id_b);
  return_response(id_b, req_b, 1'b1);
  finish_test("flush");
endtask

`endif

//--- verification/tb_load_unit.sv
// load unit testbench with clock, reset, data cache model, timeout and summary

`timescale 1ns/1ps

`include "load_unit_defines.svh"

module tb_load_unit;

  // directed tests take about 250 cycles and the run stops at eight times that
  localparam int unsigned MAX_CYCLES = 2000;
  localparam int unsigned SEED       = 97409;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        flush_i;
  logic                        valid_i;
  load_unit_pkg::load_req_t    ld_req_i;
  logic                        pop_ld_o;
  logic [11:0]                 page_offset_o;
  logic                        page_offset_matches_i;
  load_unit_pkg::dcache_req_t  dcache_req_o;
  load_unit_pkg::dcache_rsp_t  dcache_rsp_i;
  logic                        valid_o;
  load_unit_pkg::load_rsp_t    ld_rsp_o;

  int unsigned cycle_count = 0;
  int unsigned errors      = 0;
  int unsigned test_errors = 0;
  int unsigned tests_run   = 0;

  load_unit DUT (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .ld_req_i              (ld_req_i),
    .pop_ld_o              (pop_ld_o),
    .page_offset_o         (page_offset_o),
    .page_offset_matches_i (page_offset_matches_i),
    .dcache_req_o          (dcache_req_o),
    .dcache_rsp_i          (dcache_rsp_i),
    .valid_o               (valid_o),
    .ld_rsp_o              (ld_rsp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // hard stop in case a handshake never completes
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // cache data model and expected results
  // ------------------------------------------------------------------------
  // byte k of the word at A is the low byte of (A + k) * 7 + 0x5A
  function automatic load_unit_pkg::xlen_t model_word(input load_unit_pkg::addr_t addr);
    load_unit_pkg::addr_t base;
    load_unit_pkg::addr_t value;
    load_unit_pkg::xlen_t word;
    int unsigned          k;
    base = {addr[`LU_ADDR_W-1:3], 3'b000};
    word = '0;
    for (k = 0; k < 8; k++) begin
      value = (base + k) * 7 + 32'h5A;
      word[k*8 +: 8] = value[7:0];
    end
    return word;
  endfunction

  // bytes moved by each load width
  function automatic int unsigned op_bytes(input load_unit_pkg::ld_op_e op);
    case (op)
      load_unit_pkg::LB, load_unit_pkg::LBU: return 1;
      load_unit_pkg::LH, load_unit_pkg::LHU: return 2;
      load_unit_pkg::LW, load_unit_pkg::LWU: return 4;
      default: return 8;
    endcase
  endfunction

  // cache size code is the log2 of the bytes moved
  function automatic logic [1:0] size_code(input load_unit_pkg::ld_op_e op);
    case (op_bytes(op))
      1: return 2'd0;
      2: return 2'd1;
      4: return 2'd2;
      default: return 2'd3;
    endcase
  endfunction

  // pick the addressed bytes, then fill upward with the sign or with zero
  function automatic load_unit_pkg::xlen_t expected_result(input load_unit_pkg::addr_t addr,
                                                           input load_unit_pkg::ld_op_e op);
    load_unit_pkg::xlen_t word;
    load_unit_pkg::xlen_t res;
    int unsigned          n;
    int unsigned          off;
    int unsigned          k;
    logic                 sign;
    word = model_word(addr);
    n    = op_bytes(op);
    off  = 32'(addr[2:0]);
    res  = '0;
    for (k = 0; k < n; k++) begin
      res[k*8 +: 8] = word[(off + k)*8 +: 8];
    end
    sign = (op == load_unit_pkg::LB || op == load_unit_pkg::LH || op == load_unit_pkg::LW) &&
           res[n*8-1];
    for (k = n; k < 8; k++) begin
      res[k*8 +: 8] = {8{sign}};
    end
    return res;
  endfunction

  // request with byte enables covering the loaded field
  function automatic load_unit_pkg::load_req_t make_req(input int unsigned id,
                                                        input load_unit_pkg::addr_t addr,
                                                        input load_unit_pkg::ld_op_e op);
    load_unit_pkg::load_req_t req;
    int unsigned              n;
    int unsigned              off;
    int unsigned              k;
    n   = op_bytes(op);
    off = 32'(addr[2:0]);
    req = '0;
    req.trans_id = load_unit_pkg::trans_id_t'(id);
    req.addr     = addr;
    req.op       = op;
    for (k = 0; k < n; k++) begin
      req.be[off + k] = 1'b1;
    end
    return req;
  endfunction

  // ------------------------------------------------------------------------
  // reporting
  // ------------------------------------------------------------------------
  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errors);
    end
    tests_run++;
    test_errors = 0;
  endtask

  // ------------------------------------------------------------------------
  // issue side and cache handshakes
  // ------------------------------------------------------------------------
  // present a request, grant it after delay cycles, then check both cache phases
  task automatic issue_load(input load_unit_pkg::load_req_t req, input int unsigned delay,
                            output load_unit_pkg::req_id_t id);
    int unsigned c;
    @(negedge clk_i);
    valid_i               = 1'b1;
    ld_req_i              = req;
    dcache_rsp_i.data_gnt = (delay == 0);
    for (c = 0; c < delay; c++) begin
      #1;
      if (dcache_req_o.data_req !== 1'b1) report_error("data_req low while waiting for grant");
      if (pop_ld_o !== 1'b0) report_error("pop_ld_o high before the grant");
      @(negedge clk_i);
      dcache_rsp_i.data_gnt = (c == delay - 1);
    end
    #1;
    if (dcache_req_o.data_req !== 1'b1) report_error("data_req low in the grant cycle");
    if (pop_ld_o !== 1'b1) report_error("pop_ld_o low in the grant cycle");
    if (dcache_req_o.address_index !== req.addr[`LU_INDEX_W-1:0]) begin
      report_error($sformatf("index %h, expected %h", dcache_req_o.address_index,
                             req.addr[`LU_INDEX_W-1:0]));
    end
    if (dcache_req_o.data_be !== req.be) begin
      report_error($sformatf("byte enables %b, expected %b", dcache_req_o.data_be, req.be));
    end
    if (dcache_req_o.data_size !== size_code(req.op)) begin
      report_error($sformatf("data_size %0d, expected %0d", dcache_req_o.data_size,
                             size_code(req.op)));
    end
    id = dcache_req_o.data_id;
    @(negedge clk_i);
    valid_i               = 1'b0;
    dcache_rsp_i.data_gnt = 1'b0;
    #1;
    // the tag phase comes exactly one cycle after the grant
    if (pop_ld_o !== 1'b0) report_error("pop_ld_o held for more than one cycle");
    if (dcache_req_o.tag_valid !== 1'b1) report_error("tag_valid low after the grant");
    if (dcache_req_o.kill_req !== 1'b0) report_error("kill_req high without a flush");
    if (dcache_req_o.address_tag !== req.addr[`LU_ADDR_W-1:`LU_INDEX_W]) begin
      report_error($sformatf("tag %h, expected %h", dcache_req_o.address_tag,
                             req.addr[`LU_ADDR_W-1:`LU_INDEX_W]));
    end
  endtask

  // one rvalid cycle with model data for req, then check the result
  task automatic return_response(input load_unit_pkg::req_id_t id,
                                 input load_unit_pkg::load_req_t req,
                                 input logic expect_valid);
    load_unit_pkg::xlen_t exp_result;
    exp_result = expected_result(req.addr, req.op);
    @(negedge clk_i);
    dcache_rsp_i.data_rvalid = 1'b1;
    dcache_rsp_i.data_rid    = id;
    dcache_rsp_i.data_rdata  = model_word(req.addr);
    #1;
    if (valid_o !== expect_valid) begin
      report_error($sformatf("valid_o %b, expected %b", valid_o, expect_valid));
    end
    if (expect_valid && valid_o === 1'b1) begin
      if (ld_rsp_o.trans_id !== req.trans_id) begin
        report_error($sformatf("trans_id %0d, expected %0d", ld_rsp_o.trans_id, req.trans_id));
      end
      if (ld_rsp_o.result !== exp_result) begin
        report_error($sformatf("%s at %h: result %h, expected %h", req.op.name(), req.addr,
                               ld_rsp_o.result, exp_result));
      end
    end
    @(negedge clk_i);
    dcache_rsp_i.data_rvalid = 1'b0;
  endtask

  `include "tb_load_unit_tasks.svh"

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    valid_i               = 1'b0;
    ld_req_i              = '0;
    page_offset_matches_i = 1'b0;
    dcache_rsp_i          = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_reset();
    test_extension();
    test_delayed_grant();
    test_page_offset_stall();
    test_out_of_order();
    test_flush();

    $display("tests run: %0d, checks failed: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- src/load_unit.sv
// load unit top: issues loads to the data cache and returns aligned results

`timescale 1ns/1ps

`include "load_unit_defines.svh"

module load_unit (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  // issue FIFO side
  input  logic                      valid_i,
  input  load_unit_pkg::load_req_t  ld_req_i,
  output logic                      pop_ld_o,
  // store unit address check
  output logic [11:0]               page_offset_o,
  input  logic                      page_offset_matches_i,
  // data cache port
  output load_unit_pkg::dcache_req_t dcache_req_o,
  input  load_unit_pkg::dcache_rsp_t dcache_rsp_i,
  // result side, no back-pressure
  output logic                      valid_o,
  output load_unit_pkg::load_rsp_t  ld_rsp_o
);

  logic                        buf_full;
  logic                        buf_wr;
  load_unit_pkg::req_id_t      free_id;
  load_unit_pkg::req_id_t      last_id;
  load_unit_pkg::ldbuf_entry_t wr_entry;
  load_unit_pkg::ldbuf_entry_t rd_entry;
  logic                        rd_flushed;
  load_unit_pkg::xlen_t        result;

  // ------------------------------------------------------------------------
  // request path
  // ------------------------------------------------------------------------
  // store unit compares against the untranslated page offset
  assign page_offset_o = ld_req_i.addr[11:0];

  assign dcache_req_o.address_index = ld_req_i.addr[`LU_INDEX_W-1:0];
  assign dcache_req_o.data_be       = ld_req_i.be;
  // the buffer slot that the grant will fill is the request id
  assign dcache_req_o.data_id       = free_id;

  load_ctrl u_load_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .ld_req_i              (ld_req_i),
    .buf_full_i            (buf_full),
    .page_offset_matches_i (page_offset_matches_i),
    .data_gnt_i            (dcache_rsp_i.data_gnt),
    .pop_ld_o              (pop_ld_o),
    .data_req_o            (dcache_req_o.data_req),
    .tag_valid_o           (dcache_req_o.tag_valid),
    .kill_req_o            (dcache_req_o.kill_req),
    .tag_o                 (dcache_req_o.address_tag),
    .data_size_o           (dcache_req_o.data_size)
  );

  // ------------------------------------------------------------------------
  // outstanding loads
  // ------------------------------------------------------------------------
  // a granted request is tracked from the grant cycle on
  assign buf_wr = dcache_req_o.data_req & dcache_rsp_i.data_gnt;

  assign wr_entry.trans_id = ld_req_i.trans_id;
  assign wr_entry.byte_off = ld_req_i.addr[2:0];
  assign wr_entry.op       = ld_req_i.op;

  load_buffer #(
    .NR_ENTRIES (`LU_NR_LDBUF)
  ) u_load_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .wr_i         (buf_wr),
    .wr_entry_i   (wr_entry),
    .rd_i         (dcache_rsp_i.data_rvalid),
    .rd_id_i      (dcache_rsp_i.data_rid),
    .free_id_o    (free_id),
    .full_o       (buf_full),
    .rd_entry_o   (rd_entry),
    .rd_flushed_o (rd_flushed),
    .last_id_o    (last_id)
  );

  // ------------------------------------------------------------------------
  // response path
  // ------------------------------------------------------------------------
  load_align u_load_align (
    .rdata_i  (dcache_rsp_i.data_rdata),
    .entry_i  (rd_entry),
    .result_o (result)
  );

  // drop responses to flushed slots, and to the newest load while it is killed
  assign valid_o = dcache_rsp_i.data_rvalid & ~rd_flushed &
                   ~((last_id == dcache_rsp_i.data_rid) & dcache_req_o.kill_req);

  assign ld_rsp_o.trans_id = rd_entry.trans_id;
  assign ld_rsp_o.result   = result;

endmodule

//--- src/load_ctrl.sv
// load control FSM: request, grant wait, tag phase, store stall and flush kill

`timescale 1ns/1ps

`include "load_unit_defines.svh"

module load_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     valid_i,
  input  load_unit_pkg::load_req_t ld_req_i,
  input  logic                     buf_full_i,
  input  logic                     page_offset_matches_i,
  input  logic                     data_gnt_i,
  output logic                     pop_ld_o,
  output logic                     data_req_o,
  output logic                     tag_valid_o,
  output logic                     kill_req_o,
  output logic [`LU_TAG_W-1:0]     tag_o,
  output logic [1:0]               data_size_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_PAGE_OFFSET,
    WAIT_GNT,
    SEND_TAG,
    WAIT_FLUSH
  } ld_state_e;

  ld_state_e            state_d;
  ld_state_e            state_q;
  logic                 accept_req;
  logic [`LU_TAG_W-1:0] tag_q;

  // a new load can start only if the buffer has a slot for it
  assign accept_req = valid_i & ~buf_full_i;

  // ------------------------------------------------------------------------
  // next state and cache handshake
  // ------------------------------------------------------------------------
  always_comb begin
    state_d     = state_q;
    data_req_o  = 1'b0;
    pop_ld_o    = 1'b0;
    tag_valid_o = 1'b0;
    kill_req_o  = 1'b0;

    unique case (state_q)
      // SEND_TAG overlaps the tag of the previous load with a new request
      IDLE, SEND_TAG: begin
        if (state_q == SEND_TAG) begin
          tag_valid_o = 1'b1;
          // flush in the tag cycle kills that load right away
          kill_req_o  = flush_i;
          state_d     = IDLE;
        end
        if (accept_req) begin
          if (page_offset_matches_i) begin
            // pending store to the same offset, hold the request back
            state_d = WAIT_PAGE_OFFSET;
          end else begin
            data_req_o = 1'b1;
            if (data_gnt_i) begin
              pop_ld_o = 1'b1;
              state_d  = SEND_TAG;
            end else begin
              state_d = WAIT_GNT;
            end
          end
        end
      end

      // request goes out the cycle after the match clears
      WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          state_d = WAIT_GNT;
        end
      end

      // keep data_req up until the cache takes it
      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          pop_ld_o = 1'b1;
          state_d  = SEND_TAG;
        end
      end

      // one kill cycle so the cache drops whatever is in its tag stage
      WAIT_FLUSH: begin
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // flush wins over everything, no new grant is taken in the flush cycle
    if (flush_i) begin
      data_req_o = 1'b0;
      pop_ld_o   = 1'b0;
      state_d    = WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------------------------------
  // tag phase and transfer size
  // ------------------------------------------------------------------------
  // tag of the granted address is presented one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (data_req_o && data_gnt_i) begin
      tag_q <= ld_req_i.addr[`LU_ADDR_W-1:`LU_INDEX_W];
    end
  end

  assign tag_o = tag_q;

  // size encoding: 0 byte, 1 half, 2 word, 3 double
  always_comb begin
    unique case (ld_req_i.op)
      load_unit_pkg::LB, load_unit_pkg::LBU: data_size_o = 2'b00;
      load_unit_pkg::LH, load_unit_pkg::LHU: data_size_o = 2'b01;
      load_unit_pkg::LW, load_unit_pkg::LWU: data_size_o = 2'b10;
      default:                               data_size_o = 2'b11;
    endcase
  end

endmodule

//--- src/load_buffer.sv
// load buffer that tracks outstanding loads by cache request id

`timescale 1ns/1ps

`include "load_unit_defines.svh"

module load_buffer #(
  parameter int unsigned NR_ENTRIES = `LU_NR_LDBUF,
  localparam int unsigned ID_W      = (NR_ENTRIES > 1) ? $clog2(NR_ENTRIES) : 1
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  // allocation on grant
  input  logic                        wr_i,
  input  load_unit_pkg::ldbuf_entry_t wr_entry_i,
  // release on response
  input  logic                        rd_i,
  input  logic [ID_W-1:0]             rd_id_i,
  output logic [ID_W-1:0]             free_id_o,
  output logic                        full_o,
  output load_unit_pkg::ldbuf_entry_t rd_entry_o,
  output logic                        rd_flushed_o,
  output logic [ID_W-1:0]             last_id_o
);

  load_unit_pkg::ldbuf_entry_t [NR_ENTRIES-1:0] mem_q;
  logic [NR_ENTRIES-1:0] valid_d;
  logic [NR_ENTRIES-1:0] valid_q;
  logic [NR_ENTRIES-1:0] flushed_d;
  logic [NR_ENTRIES-1:0] flushed_q;
  logic [ID_W-1:0]       last_id_q;

  assign full_o = &valid_q;

  // ------------------------------------------------------------------------
  // lowest free slot
  // ------------------------------------------------------------------------
  // scan from the top so the lowest free index is the one left standing
  always_comb begin
    free_id_o = '0;
    for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_id_o = ID_W'(i);
      end
    end
  end

  // ------------------------------------------------------------------------
  // slot flags
  // ------------------------------------------------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // every load in flight becomes stale on a flush
    if (flush_i) begin
      flushed_d = '1;
    end
    if (rd_i) begin
      valid_d[rd_id_i] = 1'b0;
    end
    // a fresh load is never stale, even in the flush cycle
    if (wr_i) begin
      valid_d[free_id_o]   = 1'b1;
      flushed_d[free_id_o] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      last_id_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      if (wr_i) begin
        last_id_q <= free_id_o;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      mem_q[free_id_o] <= wr_entry_i;
    end
  end

  // combinational read at the echoed id
  assign rd_entry_o   = mem_q[rd_id_i];
  assign rd_flushed_o = flushed_q[rd_id_i];
  assign last_id_o    = last_id_q;

endmodule

//--- src/load_align.sv
// load align: shifts cache read data to the load address and extends it

`timescale 1ns/1ps

`include "load_unit_defines.svh"

module load_align (
  input  load_unit_pkg::xlen_t        rdata_i,
  input  load_unit_pkg::ldbuf_entry_t entry_i,
  output load_unit_pkg::xlen_t        result_o
);

  load_unit_pkg::xlen_t      shifted;
  logic [`LU_XLEN/8-1:0]     byte_msb;
  load_unit_pkg::byte_off_t  sign_byte;
  logic                      is_signed;
  logic                      sign_bit;

  // ------------------------------------------------------------------------
  // realign
  // ------------------------------------------------------------------------
  // addressed byte moves down to bit 0
  assign shifted = rdata_i >> {entry_i.byte_off, 3'b000};

  // ------------------------------------------------------------------------
  // sign bit
  // ------------------------------------------------------------------------
  // picked from the unshifted data so it runs beside the shifter
  for (genvar i = 0; i < `LU_XLEN / 8; i++) begin : gen_byte_msb
    assign byte_msb[i] = rdata_i[i*8+7];
  end

  assign is_signed = entry_i.op inside {load_unit_pkg::LB, load_unit_pkg::LH,
                                        load_unit_pkg::LW};

  // top byte of the loaded field
  always_comb begin
    unique case (entry_i.op)
      load_unit_pkg::LW, load_unit_pkg::LWU: sign_byte = entry_i.byte_off + 3'd3;
      load_unit_pkg::LH, load_unit_pkg::LHU: sign_byte = entry_i.byte_off + 3'd1;
      default:                               sign_byte = entry_i.byte_off;
    endcase
  end

  // unsigned loads fill with zero
  assign sign_bit = is_signed & byte_msb[sign_byte];

  // ------------------------------------------------------------------------
  // width select
  // ------------------------------------------------------------------------
  always_comb begin
    unique case (entry_i.op)
      load_unit_pkg::LW, load_unit_pkg::LWU:
        result_o = {{(`LU_XLEN - 32){sign_bit}}, shifted[31:0]};
      load_unit_pkg::LH, load_unit_pkg::LHU:
        result_o = {{(`LU_XLEN - 16){sign_bit}}, shifted[15:0]};
      load_unit_pkg::LB, load_unit_pkg::LBU:
        result_o = {{(`LU_XLEN - 8){sign_bit}}, shifted[7:0]};
      // LD, full word as is
      default:
        result_o = shifted;
    endcase
  end

endmodule

//--- src/load_unit_pkg.sv
// load unit types: data words, ids, load operations and the port bundles

`include "load_unit_defines.svh"

package load_unit_pkg;

  // ------------------------------------------------------------------------
  // plain vectors
  // ------------------------------------------------------------------------
  typedef logic [`LU_XLEN-1:0]       xlen_t;
  typedef logic [`LU_ADDR_W-1:0]     addr_t;
  typedef logic [`LU_TRANS_ID_W-1:0] trans_id_t;
  // load buffer slot, doubles as the cache request id
  typedef logic [`LU_REQ_ID_W-1:0]   req_id_t;
  // byte position inside one 64 bit word
  typedef logic [2:0]                byte_off_t;

  // load operations, signed and unsigned per width
  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    LWU,
    LD
  } ld_op_e;

  // ------------------------------------------------------------------------
  // bundles
  // ------------------------------------------------------------------------
  // one request from the issue FIFO
  typedef struct packed {
    trans_id_t                 trans_id;
    addr_t                     addr;
    ld_op_e                    op;
    logic [`LU_XLEN/8-1:0]     be;
  } load_req_t;

  // what is kept per outstanding load until its response returns
  typedef struct packed {
    trans_id_t trans_id;
    byte_off_t byte_off;
    ld_op_e    op;
  } ldbuf_entry_t;

  // unit to data cache
  typedef struct packed {
    logic                      data_req;
    logic [`LU_INDEX_W-1:0]    address_index;
    logic [`LU_TAG_W-1:0]      address_tag;
    logic [`LU_XLEN/8-1:0]     data_be;
    logic [1:0]                data_size;
    req_id_t                   data_id;
    logic                      kill_req;
    logic                      tag_valid;
  } dcache_req_t;

  // data cache to unit
  typedef struct packed {
    logic    data_gnt;
    logic    data_rvalid;
    req_id_t data_rid;
    xlen_t   data_rdata;
  } dcache_rsp_t;

  // result towards the scoreboard
  typedef struct packed {
    trans_id_t trans_id;
    xlen_t     result;
  } load_rsp_t;

endpackage

//--- src/load_unit_defines.svh
// load unit widths and sizes shared by package, RTL and testbench

`ifndef LOAD_UNIT_DEFINES_SVH
`define LOAD_UNIT_DEFINES_SVH

// data path width
`define LU_XLEN 64
// load address width
`define LU_ADDR_W 32
// cache index, the low address bits that go out with the request phase
`define LU_INDEX_W 12
// cache tag, the rest of the address, sent one cycle after the grant
`define LU_TAG_W (`LU_ADDR_W - `LU_INDEX_W)
// scoreboard id of a load
`define LU_TRANS_ID_W 3
// outstanding loads tracked by the load buffer
`define LU_NR_LDBUF 2
// cache request id, log2 of the buffer size with a floor of 1
`define LU_REQ_ID_W 1

`endif
